/* Makefile */
SOURCES := $(shell grep -v '^+' list.f) source/clock_config.svh

all: run

obj_dir/Vtb_digital_clock: list.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_digital_clock

run: obj_dir/Vtb_digital_clock
	./obj_dir/Vtb_digital_clock | tee sim.log
	grep -qx "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* list.f */
+incdir+source
source/clock_pkg.sv
source/tick_timer.sv
source/time_counter.sv
source/alarm_setter.sv
source/alarm_ring.sv
source/seg_scanner.sv
source/mode_fsm.sv
source/digital_clock_top.sv
sim/tb_digital_clock.sv

/* sim/tb_digital_clock.sv */
`timescale 1ns/1ps
`include "clock_config.svh"

module tb_digital_clock;

    import clock_pkg::*;

    // wait limits for one second step and one scan step
    localparam int STEP_LIMIT = 2 * `CLOCK_TICK_DIV + 2;
    localparam int SCAN_LIMIT = 2 * `CLOCK_SCAN_DIV + 2;
    // longest adjust burst on one field
    localparam int BURST_MAX  = 64;
    // twelve bursts, forty seconds of counting, two full scans, key presses, doubled
    localparam int TIMEOUT_CYCLES =
        2 * (12 * BURST_MAX + 40 * `CLOCK_TICK_DIV + 16 * `CLOCK_SCAN_DIV + 200);

    logic        clk_group;
    logic        arst_n;
    logic        power;
    logic        run_enable;
    logic        alarm_enable;
    logic        mode_key;
    logic        stop_key;
    adjust_t     adjust;
    hms_t        time_now;
    logic [7:0]  anodes;
    seg_t        cathodes;
    logic        alarm;

    // bookkeeping
    int          error_count;
    int          cycle_count;
    int          seed;
    string       test_name;
    logic        alarm_seen;
    // reference model of the clock
    hms_t        ref_time;
    hms_t        ref_alarm;
    clock_mode_e cur_mode;

    digital_clock_top i_digital_clock_top (
        .clk_group    (clk_group),
        .arst_n       (arst_n),
        .power        (power),
        .run_enable   (run_enable),
        .alarm_enable (alarm_enable),
        .mode_key     (mode_key),
        .stop_key     (stop_key),
        .adjust       (adjust),
        .time_now     (time_now),
        .anodes       (anodes),
        .cathodes     (cathodes),
        .alarm        (alarm)
    );

    // 100 ns period
    always #50 clk_group = ~clk_group;

    // watchdog
    always @(posedge clk_group) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d, cycles: %0d", error_count + 1, cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////
    // checking
    ////////////////////

    task automatic compare(input string label, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s, %s: expected %0h actual %0h",
                     test_name, label, expected, actual);
            error_count++;
        end
    endtask

    task automatic report(input string what);
        $display("%s: %s", test_name, what);
        error_count++;
    endtask

    ////////////////////
    // reference model
    ////////////////////

    function automatic hms_t hms(input int h, input int m, input int s);
        hms_t t;
        t.hour = hour_t'(h);
        t.min  = min_t'(m);
        t.sec  = sec_t'(s);
        return t;
    endfunction

    // via seconds since midnight, one day wrap
    function automatic hms_t add_seconds(input hms_t t, input int n);
        int total;
        total = (int'(t.hour) * 3600 + int'(t.min) * 60 + int'(t.sec) + n) % 86400;
        return hms(total / 3600, (total / 60) % 60, total % 60);
    endfunction

    // field 0 seconds, 1 minutes, 2 hours
    function automatic int field_range(input int f);
        return (f == 2) ? 24 : 60;
    endfunction

    function automatic int field_of(input hms_t t, input int f);
        case (f)
            0: return int'(t.sec);
            1: return int'(t.min);
            default: return int'(t.hour);
        endcase
    endfunction

    // one field moved with wrap, no carry into the others
    function automatic hms_t shift_field(input hms_t t, input int f, input int delta);
        int   v;
        hms_t r;
        v = ((field_of(t, f) + delta) % field_range(f) + field_range(f)) % field_range(f);
        r = t;
        case (f)
            0: r.sec = sec_t'(v);
            1: r.min = min_t'(v);
            default: r.hour = hour_t'(v);
        endcase
        return r;
    endfunction

    // lit segments gfedcba
    function automatic logic [7:0] lit_segments(input int d);
        case (d)
            0: return 8'h3F;
            1: return 8'h06;
            2: return 8'h5B;
            3: return 8'h4F;
            4: return 8'h66;
            5: return 8'h6D;
            6: return 8'h7D;
            7: return 8'h07;
            8: return 8'h7F;
            9: return 8'h6F;
            default: return 8'h00;
        endcase
    endfunction

    // cathodes for one display position, blanks at 5 and 2
    function automatic seg_t expected_segments(input hms_t t, input int pos);
        int value;
        case (pos)
            7: value = int'(t.hour) / 10;
            6: value = int'(t.hour) % 10;
            4: value = int'(t.min) / 10;
            3: value = int'(t.min) % 10;
            1: value = int'(t.sec) / 10;
            0: value = int'(t.sec) % 10;
            default: value = -1;
        endcase
        if (value < 0) begin
            return 8'hFF;
        end
        // active low, point off
        return ~lit_segments(value);
    endfunction

    ////////////////////
    // stimulus
    ////////////////////

    task automatic press_mode_key();
        @(posedge clk_group);
        mode_key <= 1'b1;
        @(posedge clk_group);
        mode_key <= 1'b0;
        case (cur_mode)
            MODE_RUN:      cur_mode = MODE_SET_TIME;
            MODE_SET_TIME: cur_mode = MODE_SET_ALARM;
            default:       cur_mode = MODE_RUN;
        endcase
        @(negedge clk_group);
        compare("mode after key", 32'(cur_mode), 32'(i_digital_clock_top.mode));
    endtask

    // stop counting first so no step goes unseen by the model
    task automatic enter_mode(input clock_mode_e target);
        @(posedge clk_group);
        run_enable <= 1'b0;
        while (cur_mode != target) begin
            press_mode_key();
        end
    endtask

    // same adjust value for n cycles
    task automatic drive_burst(input adjust_t a, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk_group);
            adjust <= a;
        end
        @(posedge clk_group);
        adjust <= '0;
        @(negedge clk_group);
    endtask

    // add pulses only, each field its own count
    task automatic move_fields(input hms_t from, input hms_t target);
        int      count [3];
        int      longest;
        adjust_t step;
        longest = 0;
        for (int f = 0; f < 3; f++) begin
            count[f] = (field_of(target, f) - field_of(from, f) + field_range(f))
                       % field_range(f);
            if (count[f] > longest) begin
                longest = count[f];
            end
        end
        for (int i = 0; i < longest; i++) begin
            step = '0;
            for (int f = 0; f < 3; f++) begin
                if (i < count[f]) begin
                    step.add[f] = 1'b1;
                end
            end
            @(posedge clk_group);
            adjust <= step;
        end
        @(posedge clk_group);
        adjust <= '0;
        @(negedge clk_group);
    endtask

    task automatic preset_time(input hms_t target);
        enter_mode(MODE_SET_TIME);
        move_fields(ref_time, target);
        ref_time = target;
        compare("preset time", 32'(ref_time), 32'(time_now));
        enter_mode(MODE_RUN);
    endtask

    task automatic set_alarm(input hms_t target);
        enter_mode(MODE_SET_ALARM);
        move_fields(ref_alarm, target);
        ref_alarm = target;
        compare("alarm time", 32'(ref_alarm), 32'(i_digital_clock_top.alarm_time));
        enter_mode(MODE_RUN);
    endtask

    // next counting step, model moves one second
    task automatic wait_step(output int waited);
        logic found;
        waited = 0;
        found  = 1'b0;
        while (!found && waited < STEP_LIMIT) begin
            @(negedge clk_group);
            waited++;
            alarm_seen = alarm_seen | alarm;
            found = i_digital_clock_top.time_step;
        end
        if (!found) begin
            report($sformatf("no time step within %0d cycles", STEP_LIMIT));
        end else begin
            ref_time = add_seconds(ref_time, 1);
            compare("time after step", 32'(ref_time), 32'(time_now));
        end
    endtask

    task automatic run_seconds(input int n);
        int waited;
        for (int i = 0; i < n; i++) begin
            wait_step(waited);
            // each step follows one second tick
            if (i > 0) begin
                compare("tick spacing", 32'(`CLOCK_TICK_DIV), 32'(waited));
            end
        end
    endtask

    // time must not move at all
    task automatic check_hold(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk_group);
            if (i_digital_clock_top.time_step) begin
                report("time counted while it should hold");
            end
        end
        compare("held time", 32'(ref_time), 32'(time_now));
    endtask

    // alarm up exactly 3 cycles after the matching step
    task automatic check_rise();
        for (int c = 1; c <= 3; c++) begin
            @(negedge clk_group);
            compare("alarm rise timing", 32'(c == 3), 32'(alarm));
        end
    endtask

    // eight positions, each one-hot-low with the right digit
    task automatic check_scan(input hms_t shown);
        logic [7:0] seen;
        int         pos;
        int         waited;
        seen = '0;
        @(negedge clk_group);
        for (int s = 0; s < 8; s++) begin
            waited = 0;
            while (!i_digital_clock_top.scan_step && waited < SCAN_LIMIT) begin
                @(negedge clk_group);
                waited++;
            end
            if (!i_digital_clock_top.scan_step) begin
                report($sformatf("no scan step within %0d cycles", SCAN_LIMIT));
            end else begin
                @(negedge clk_group);
                pos = -1;
                for (int p = 0; p < 8; p++) begin
                    if (anodes == ~(8'b1 << p)) begin
                        pos = p;
                    end
                end
                if (pos < 0) begin
                    report($sformatf("anodes %b do not select exactly one digit", anodes));
                end else begin
                    seen[pos] = 1'b1;
                    compare("cathodes", 32'(expected_segments(shown, pos)), 32'(cathodes));
                end
            end
        end
        compare("digits scanned", 32'(8'hFF), 32'(seen));
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic test_reset();
        test_name = "reset";
        @(negedge clk_group);
        compare("time", 32'(hms(0, 0, 0)), 32'(time_now));
        compare("alarm", 32'(0), 32'(alarm));
        compare("anodes", 32'(8'hFF), 32'(anodes));
        compare("mode", 32'(MODE_RUN), 32'(i_digital_clock_top.mode));
    endtask

    task automatic test_counting();
        test_name = "counting";
        // full carry chain and midnight wrap
        preset_time(hms(23, 59, 58));
        @(posedge clk_group);
        run_enable <= 1'b1;
        run_seconds(3);
        compare("after wrap", 32'(hms(0, 0, 1)), 32'(time_now));
        // hour carry without wrap
        preset_time(hms(9, 59, 59));
        @(posedge clk_group);
        run_enable <= 1'b1;
        run_seconds(1);
        compare("hour carry", 32'(hms(10, 0, 0)), 32'(time_now));
        // run switch off
        @(posedge clk_group);
        run_enable <= 1'b0;
        check_hold(3 * `CLOCK_TICK_DIV);
    endtask

    task automatic test_setting();
        int      adds;
        int      subs;
        adjust_t a;
        test_name = "setting";
        enter_mode(MODE_SET_TIME);
        for (int f = 0; f < 3; f++) begin
            adds = ($random(seed) & 31) + 1;
            subs = ($random(seed) & 31) + 1;
            a = '0;
            a.add[f] = 1'b1;
            drive_burst(a, adds);
            ref_time = shift_field(ref_time, f, adds);
            compare("field after add", 32'(ref_time), 32'(time_now));
            a = '0;
            a.sub[f] = 1'b1;
            drive_burst(a, subs);
            ref_time = shift_field(ref_time, f, -subs);
            compare("field after sub", 32'(ref_time), 32'(time_now));
        end
        // ticks ignored while setting
        @(posedge clk_group);
        run_enable <= 1'b1;
        check_hold(3 * `CLOCK_TICK_DIV);
        enter_mode(MODE_RUN);
        // one full lap of the modes
        repeat (3) begin
            press_mode_key();
        end
    endtask

    task automatic test_alarm();
        test_name = "alarm ring";
        set_alarm(add_seconds(ref_time, 3));
        @(posedge clk_group);
        run_enable <= 1'b1;
        run_seconds(3);
        check_rise();
        repeat (`CLOCK_RING_SECONDS - 1) begin
            run_seconds(1);
            compare("alarm while ringing", 32'(1), 32'(alarm));
        end
        run_seconds(1);
        compare("alarm after ring length", 32'(0), 32'(alarm));

        test_name = "alarm stop";
        set_alarm(add_seconds(ref_time, 3));
        @(posedge clk_group);
        run_enable <= 1'b1;
        run_seconds(3);
        check_rise();
        @(posedge clk_group);
        stop_key <= 1'b1;
        @(posedge clk_group);
        stop_key <= 1'b0;
        @(negedge clk_group);
        compare("alarm after stop", 32'(0), 32'(alarm));
        run_seconds(1);
        compare("alarm stays off", 32'(0), 32'(alarm));

        test_name = "alarm disabled";
        set_alarm(add_seconds(ref_time, 3));
        @(posedge clk_group);
        alarm_enable <= 1'b0;
        run_enable   <= 1'b1;
        alarm_seen = 1'b0;
        run_seconds(5);
        compare("alarm seen", 32'(0), 32'(alarm_seen));
        @(posedge clk_group);
        alarm_enable <= 1'b1;
    endtask

    task automatic test_display();
        test_name = "display";
        // frozen running time
        enter_mode(MODE_RUN);
        check_scan(ref_time);
        // stored alarm while it is being set
        enter_mode(MODE_SET_ALARM);
        check_scan(ref_alarm);
        enter_mode(MODE_RUN);
    endtask

    task automatic test_power();
        test_name = "power";
        set_alarm(add_seconds(ref_time, 3));
        @(posedge clk_group);
        run_enable <= 1'b1;
        run_seconds(3);
        check_rise();
        // ringing in a setting mode
        enter_mode(MODE_SET_TIME);
        compare("alarm before power loss", 32'(1), 32'(alarm));
        @(posedge clk_group);
        power      <= 1'b0;
        run_enable <= 1'b1;
        @(negedge clk_group);
        compare("alarm at power loss", 32'(0), 32'(alarm));
        @(negedge clk_group);
        compare("anodes dark", 32'(8'hFF), 32'(anodes));
        cur_mode = MODE_RUN;
        compare("mode back to run", 32'(MODE_RUN), 32'(i_digital_clock_top.mode));
        check_hold(3 * `CLOCK_TICK_DIV);
        compare("anodes still dark", 32'(8'hFF), 32'(anodes));
        // ring cancelled for good
        @(posedge clk_group);
        power      <= 1'b1;
        run_enable <= 1'b0;
        repeat (2) begin
            @(negedge clk_group);
        end
        compare("alarm after power returns", 32'(0), 32'(alarm));
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin
        clk_group    = 1'b0;
        arst_n       = 1'b0;
        power        = 1'b1;
        run_enable   = 1'b0;
        alarm_enable = 1'b1;
        mode_key     = 1'b0;
        stop_key     = 1'b0;
        adjust       = '0;
        error_count  = 0;
        cycle_count  = 0;
        seed         = 58;
        alarm_seen   = 1'b0;
        ref_time     = hms(0, 0, 0);
        ref_alarm    = hms(0, 0, 0);
        cur_mode     = MODE_RUN;

        repeat (3) @(posedge clk_group);
        arst_n <= 1'b1;

        test_reset();
        test_counting();
        test_setting();
        test_alarm();
        test_display();
        test_power();

        $display("errors: %0d, cycles: %0d", error_count, cycle_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* source/alarm_ring.sv */
`timescale 1ns/1ps
`include "clock_config.svh"

module alarm_ring (
    input  logic clk_group,
    input  logic arst_n,
    input  logic power,
    input  logic sec_tick,
    input  logic ring_start,
    input  logic stop_key,
    output logic alarm
);

    localparam int RING_W = $clog2(`CLOCK_RING_SECONDS + 1);

    logic              ring_on;
    logic [RING_W-1:0] ring_cnt;
    logic              ring_last;

    assign ring_last = (ring_cnt == RING_W'(`CLOCK_RING_SECONDS - 1));

    // power loss silences the output in the same cycle
    assign alarm = ring_on && power;

    always_ff @(posedge clk_group or negedge arst_n) begin
        if (!arst_n) begin
            ring_on  <= 1'b0;
            ring_cnt <= '0;
        end else if (!power || stop_key) begin
            // both stop conditions cancel the ring
            ring_on  <= 1'b0;
            ring_cnt <= '0;
        end else if (ring_start) begin
            ring_on  <= 1'b1;
            ring_cnt <= '0;
        end else if (ring_on && sec_tick) begin
            // count seconds rung, drop on the last one
            ring_on  <= !ring_last;
            ring_cnt <= ring_last ? '0 : ring_cnt + 1'b1;
        end
    end

    // a power dip cancels the ring, it does not resume afterwards
    a_power_cancels : assert property (
        @(posedge clk_group) disable iff (!arst_n)
        !power |=> !ring_on
    );

endmodule

/* source/alarm_setter.sv */
`timescale 1ns/1ps

module alarm_setter (
    input  logic                   clk_group,
    input  logic                   arst_n,
    input  logic                   alarm_enable,
    input  logic                   time_step,
    input  clock_pkg::clock_mode_e mode,
    input  clock_pkg::adjust_t     adjust,
    input  clock_pkg::hms_t        time_now,
    output clock_pkg::hms_t        alarm_time,
    output logic                   ring_start
);

    import clock_pkg::*;

    logic step_q;
    logic match;

    // only a running clock with the alarm armed may ring
    assign match = (time_now == alarm_time) && alarm_enable && (mode == MODE_RUN);

    always_ff @(posedge clk_group or negedge arst_n) begin
        if (!arst_n) begin
            alarm_time <= '0;
            step_q     <= 1'b0;
            ring_start <= 1'b0;
        end else begin
            // step delayed one cycle before the compare
            step_q <= time_step;

            // compare only right after a counting step
            // so setting the alarm to the shown time stays quiet
            ring_start <= step_q && match;

            // alarm fields stepped like the time fields
            if (mode == MODE_SET_ALARM) begin
                alarm_time <= adjust_hms(alarm_time, adjust);
            end
        end
    end

    // stored alarm stays a legal time of day
    a_alarm_range : assert property (
        @(posedge clk_group) disable iff (!arst_n)
        (alarm_time.sec <= SEC_LAST) && (alarm_time.min <= MIN_LAST) &&
        (alarm_time.hour <= HOUR_LAST)
    );

endmodule

/* source/clock_config.svh */
`ifndef CLOCK_CONFIG_SVH
`define CLOCK_CONFIG_SVH

////////////////////
// timing constants
////////////////////

// clk_group cycles per second tick
// small so the simulation stays short, a board build uses the oscillator rate
// keep at 2 or more
`define CLOCK_TICK_DIV 10

// clk_group cycles per display digit step
// keep at 2 or more
`define CLOCK_SCAN_DIV 4

// how many second ticks the alarm keeps ringing
`define CLOCK_RING_SECONDS 5

`endif

/* source/clock_pkg.sv */
package clock_pkg;

    ////////////////////
    // time fields
    ////////////////////

    typedef logic [5:0] sec_t;
    typedef logic [5:0] min_t;
    typedef logic [4:0] hour_t;

    // last legal value of each field
    localparam sec_t  SEC_LAST  = 6'd59;
    localparam min_t  MIN_LAST  = 6'd59;
    localparam hour_t HOUR_LAST = 5'd23;

    // 17 bits, hour in the top bits
    typedef struct packed {
        hour_t hour;
        min_t  min;
        sec_t  sec;
    } hms_t;

    // bit 0 seconds, bit 1 minutes, bit 2 hours
    typedef struct packed {
        logic [2:0] add;
        logic [2:0] sub;
    } adjust_t;

    typedef enum logic [1:0] {
        MODE_RUN       = 2'd0,
        MODE_SET_TIME  = 2'd1,
        MODE_SET_ALARM = 2'd2
    } clock_mode_e;

    // active low, {dp, g, f, e, d, c, b, a}
    typedef logic [7:0] seg_t;

    ////////////////////
    // field setting
    ////////////////////

    // one step up or down inside 0..last, no carry
    // add and sub together cancel
    function automatic logic [5:0] field_adjust(
        input logic [5:0] value,
        input logic [5:0] last,
        input logic       add,
        input logic       sub
    );
        logic [5:0] result;
        result = value;
        if (add && !sub) begin
            result = (value == last) ? 6'd0 : value + 6'd1;
        end else if (sub && !add) begin
            result = (value == 6'd0) ? last : value - 6'd1;
        end
        return result;
    endfunction

    // same step rule on all three fields at once
    function automatic hms_t adjust_hms(input hms_t value, input adjust_t adj);
        hms_t result;
        result.sec  = sec_t'(field_adjust(value.sec, SEC_LAST, adj.add[0], adj.sub[0]));
        result.min  = min_t'(field_adjust(value.min, MIN_LAST, adj.add[1], adj.sub[1]));
        result.hour = hour_t'(field_adjust(6'(value.hour), 6'(HOUR_LAST),
                                           adj.add[2], adj.sub[2]));
        return result;
    endfunction

endpackage

/* source/digital_clock_top.sv */
`timescale 1ns/1ps

module digital_clock_top (
    input  logic                clk_group,
    input  logic                arst_n,
    input  logic                power,
    input  logic                run_enable,
    input  logic                alarm_enable,
    input  logic                mode_key,
    input  logic                stop_key,
    input  clock_pkg::adjust_t  adjust,
    output clock_pkg::hms_t     time_now,
    output logic [7:0]          anodes,
    output clock_pkg::seg_t     cathodes,
    output logic                alarm
);

    import clock_pkg::*;

    // strobes
    logic        sec_tick;
    logic        scan_step;
    logic        time_step;
    logic        ring_start;
    // shared state
    clock_mode_e mode;
    hms_t        alarm_time;

    tick_timer i_tick_timer (
        .clk_group (clk_group),
        .arst_n    (arst_n),
        .power     (power),
        .sec_tick  (sec_tick),
        .scan_step (scan_step)
    );

    mode_fsm i_mode_fsm (
        .clk_group (clk_group),
        .arst_n    (arst_n),
        .power     (power),
        .mode_key  (mode_key),
        .mode      (mode)
    );

    time_counter i_time_counter (
        .clk_group  (clk_group),
        .arst_n     (arst_n),
        .run_enable (run_enable),
        .sec_tick   (sec_tick),
        .mode       (mode),
        .adjust     (adjust),
        .time_now   (time_now),
        .time_step  (time_step)
    );

    alarm_setter i_alarm_setter (
        .clk_group    (clk_group),
        .arst_n       (arst_n),
        .alarm_enable (alarm_enable),
        .time_step    (time_step),
        .mode         (mode),
        .adjust       (adjust),
        .time_now     (time_now),
        .alarm_time   (alarm_time),
        .ring_start   (ring_start)
    );

    alarm_ring i_alarm_ring (
        .clk_group  (clk_group),
        .arst_n     (arst_n),
        .power      (power),
        .sec_tick   (sec_tick),
        .ring_start (ring_start),
        .stop_key   (stop_key),
        .alarm      (alarm)
    );

    seg_scanner i_seg_scanner (
        .clk_group  (clk_group),
        .arst_n     (arst_n),
        .power      (power),
        .scan_step  (scan_step),
        .mode       (mode),
        .time_now   (time_now),
        .alarm_time (alarm_time),
        .anodes     (anodes),
        .cathodes   (cathodes)
    );

endmodule

/* source/mode_fsm.sv */
`timescale 1ns/1ps

module mode_fsm (
    input  logic                   clk_group,
    input  logic                   arst_n,
    input  logic                   power,
    input  logic                   mode_key,
    output clock_pkg::clock_mode_e mode
);

    import clock_pkg::*;

    clock_mode_e mode_next;

    ////////////////////
    // next state
    ////////////////////

    // run -> set time -> set alarm -> run
    always_comb begin
        case (mode)
            MODE_RUN:       mode_next = MODE_SET_TIME;
            MODE_SET_TIME:  mode_next = MODE_SET_ALARM;
            MODE_SET_ALARM: mode_next = MODE_RUN;
            default:        mode_next = MODE_RUN;
        endcase
    end

    ////////////////////
    // state register
    ////////////////////

    always_ff @(posedge clk_group or negedge arst_n) begin
        if (!arst_n) begin
            mode <= MODE_RUN;
        end else if (!power) begin
            // power off leaves any setting mode
            mode <= MODE_RUN;
        end else if (mode_key) begin
            mode <= mode_next;
        end
    end

endmodule

/* source/seg_scanner.sv */
`timescale 1ns/1ps

module seg_scanner (
    input  logic                   clk_group,
    input  logic                   arst_n,
    input  logic                   power,
    input  logic                   scan_step,
    input  clock_pkg::clock_mode_e mode,
    input  clock_pkg::hms_t        time_now,
    input  clock_pkg::hms_t        alarm_time,
    output logic [7:0]             anodes,
    output clock_pkg::seg_t        cathodes
);

    import clock_pkg::*;

    hms_t       shown;
    logic [2:0] digit;
    logic [3:0] nibble;
    logic       blank;
    seg_t       pattern;

    // alarm shown only while it is being set
    assign shown = (mode == MODE_SET_ALARM) ? alarm_time : time_now;

    // pick the decimal digit for the active position
    always_comb begin
        nibble = 4'd0;
        blank  = 1'b0;
        case (digit)
            3'd7: nibble = 4'(shown.hour / 5'd10);
            3'd6: nibble = 4'(shown.hour % 5'd10);
            3'd4: nibble = 4'(shown.min / 6'd10);
            3'd3: nibble = 4'(shown.min % 6'd10);
            3'd1: nibble = 4'(shown.sec / 6'd10);
            3'd0: nibble = 4'(shown.sec % 6'd10);
            // separators between the fields
            default: blank = 1'b1;
        endcase
    end

    // decimal point always off
    always_comb begin
        case (nibble)
            4'd0: pattern = 8'hC0;
            4'd1: pattern = 8'hF9;
            4'd2: pattern = 8'hA4;
            4'd3: pattern = 8'hB0;
            4'd4: pattern = 8'h99;
            4'd5: pattern = 8'h92;
            4'd6: pattern = 8'h82;
            4'd7: pattern = 8'hF8;
            4'd8: pattern = 8'h80;
            4'd9: pattern = 8'h90;
            default: pattern = 8'hFF;
        endcase
        if (blank) begin
            pattern = 8'hFF;
        end
    end

    // registered outputs, one position per scan step
    always_ff @(posedge clk_group or negedge arst_n) begin
        if (!arst_n) begin
            digit    <= '0;
            anodes   <= '1;
            cathodes <= '1;
        end else if (!power) begin
            // dark display
            anodes   <= '1;
            cathodes <= '1;
        end else if (scan_step) begin
            anodes   <= ~(8'b1 << digit);
            cathodes <= pattern;
            digit    <= digit + 1'b1;
        end
    end

    // once a step has lit a digit exactly one anode is low
    a_anodes_onehot : assert property (
        @(posedge clk_group) disable iff (!arst_n)
        (power && scan_step) ##1 power |-> $onehot(~anodes)
    );

endmodule

/* source/tick_timer.sv */
`timescale 1ns/1ps
`include "clock_config.svh"

module tick_timer (
    input  logic clk_group,
    input  logic arst_n,
    input  logic power,
    output logic sec_tick,
    output logic scan_step
);

    localparam int TICK_W = $clog2(`CLOCK_TICK_DIV);
    localparam int SCAN_W = $clog2(`CLOCK_SCAN_DIV);

    logic [TICK_W-1:0] tick_cnt;
    logic [SCAN_W-1:0] scan_cnt;
    logic              tick_last;
    logic              scan_last;

    // terminal counts
    assign tick_last = (tick_cnt == TICK_W'(`CLOCK_TICK_DIV - 1));
    assign scan_last = (scan_cnt == SCAN_W'(`CLOCK_SCAN_DIV - 1));

    // strobes only while powered
    assign sec_tick  = power && tick_last;
    assign scan_step = power && scan_last;

    // both counters stall with power off
    always_ff @(posedge clk_group or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
            scan_cnt <= '0;
        end else if (power) begin
            tick_cnt <= tick_last ? '0 : tick_cnt + 1'b1;
            scan_cnt <= scan_last ? '0 : scan_cnt + 1'b1;
        end
    end

    // second strobe is a single cycle wide
    a_sec_tick_single : assert property (
        @(posedge clk_group) disable iff (!arst_n)
        sec_tick |=> !sec_tick
    );

endmodule

/* source/time_counter.sv */
`timescale 1ns/1ps

module time_counter (
    input  logic                   clk_group,
    input  logic                   arst_n,
    input  logic                   run_enable,
    input  logic                   sec_tick,
    input  clock_pkg::clock_mode_e mode,
    input  clock_pkg::adjust_t     adjust,
    output clock_pkg::hms_t        time_now,
    output logic                   time_step
);

    import clock_pkg::*;

    hms_t time_next;
    logic count_en;
    logic sec_carry;
    logic min_carry;
    logic hour_wrap;

    ////////////////////
    // counting path
    ////////////////////

    // tick only counts in run mode with the run switch on
    assign count_en  = (mode == MODE_RUN) && run_enable && sec_tick;

    // carry chain sec -> min -> hour
    assign sec_carry = (time_now.sec == SEC_LAST);
    assign min_carry = sec_carry && (time_now.min == MIN_LAST);
    assign hour_wrap = min_carry && (time_now.hour == HOUR_LAST);

    always_comb begin
        time_next = time_now;
        time_next.sec = sec_carry ? '0 : time_now.sec + 1'b1;
        if (sec_carry) begin
            time_next.min = (time_now.min == MIN_LAST) ? '0 : time_now.min + 1'b1;
        end
        // 23:59:59 rolls to midnight
        if (hour_wrap) begin
            time_next.hour = '0;
        end else if (min_carry) begin
            time_next.hour = time_now.hour + 1'b1;
        end
    end

    ////////////////////
    // time register
    ////////////////////

    always_ff @(posedge clk_group or negedge arst_n) begin
        if (!arst_n) begin
            time_now  <= '0;
            time_step <= 1'b0;
        end else begin
            time_step <= 1'b0;
            case (mode)
                MODE_RUN: begin
                    if (count_en) begin
                        time_now  <= time_next;
                        // marks the cycle that holds the new time
                        time_step <= 1'b1;
                    end
                end
                MODE_SET_TIME: begin
                    // per field wrap, ticks ignored here
                    time_now <= adjust_hms(time_now, adjust);
                end
                default: begin
                    // alarm being set, time frozen
                    time_now <= time_now;
                end
            endcase
        end
    end

    // no field leaves its range, whether counting or being set
    a_time_range : assert property (
        @(posedge clk_group) disable iff (!arst_n)
        (time_now.sec <= SEC_LAST) && (time_now.min <= MIN_LAST) &&
        (time_now.hour <= HOUR_LAST)
    );

endmodule
